// File: source/luma_cost_cfg.svh
// Fixed at build time; cost width must hold 16 rows of 17 squares of full-range coefficients
`ifndef LUMA_COST_CFG_SVH
`define LUMA_COST_CFG_SVH

// ----------------------------------------
// Block geometry
// ----------------------------------------
// Coefficients per AC row and rows per block
`define LUMA_BLOCK_SIZE 16

// ----------------------------------------
// Widths and macroblock shape
// ----------------------------------------
`define LUMA_COEF_WIDTH 16
// 16 * 17 * 2^30 stays below 2^39
`define LUMA_COST_WIDTH 40
// Candidate blocks per macroblock, sent back to back
`define LUMA_NUM_CANDIDATES 4

`endif

// File: source/luma_cost_pkg.sv
// Types only; coefficient and cost widths come from the cfg header and mode ids are 4 bits
`include "luma_cost_cfg.svh"

package luma_cost_pkg;

    // ----------------------------------------
    // Scalar types
    // ----------------------------------------
    typedef logic signed [`LUMA_COEF_WIDTH-1:0] coef_t;
    typedef coef_t [`LUMA_BLOCK_SIZE-1:0]        coef_row_t;

    // Intra prediction mode identifier
    typedef logic [3:0] mode_t;

    // Exact, unsigned block cost
    typedef logic [`LUMA_COST_WIDTH-1:0] cost_t;

    // ----------------------------------------
    // Stage payloads
    // ----------------------------------------
    // One row beat: AC row, matching DC entry, candidate mode
    typedef struct packed {
        coef_row_t ac;
        coef_t     dc;
        mode_t     mode;
    } row_beat_t;

    typedef struct packed {
        mode_t mode;
        cost_t cost;
    } mode_cost_t;

endpackage

// File: source/pipe_stage.sv
// One-entry register slice; full throughput only when the consumer takes data every cycle
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Slot frees up when empty or when its content leaves this cycle
    assign in_ready = !out_valid || out_ready;

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Stalled output must hold until the consumer takes it
    stall_stable_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else $error("pipe_stage output changed while stalled");

endmodule

// File: source/row_energy.sv
// Two register stages, squares then sum; both stall together so at most two rows in flight
`include "luma_cost_cfg.svh"

module row_energy
    import luma_cost_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  coef_row_t in_ac,
    input  coef_t     in_dc,
    input  mode_t     in_mode,
    output logic      out_valid,
    input  logic      out_ready,
    output cost_t     out_energy,
    output mode_t     out_mode
);

    localparam int NUM_TERMS = `LUMA_BLOCK_SIZE + 1;
    localparam int SQ_WIDTH  = 2 * `LUMA_COEF_WIDTH;
    // Tree leaves rounded up to a power of two
    localparam int LEAVES    = 2 ** $clog2(NUM_TERMS);

    logic                s1_valid;
    mode_t               s1_mode;
    logic [SQ_WIDTH-1:0] sq_q [NUM_TERMS];
    cost_t               tree [1:2*LEAVES-1];
    logic                advance;

    // Whole pipe moves as one
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;

    // ----------------------------------------
    // Stage 1: signed squares
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            for (int i = 0; i < `LUMA_BLOCK_SIZE; i++) begin
                sq_q[i] <= $signed(in_ac[i]) * $signed(in_ac[i]);
            end
            // DC entry is the 17th term
            sq_q[`LUMA_BLOCK_SIZE] <= in_dc * in_dc;
            s1_mode <= in_mode;
        end
    end

    // ----------------------------------------
    // Balanced adder tree, heap indexed
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < LEAVES; i++) begin
            tree[LEAVES + i] = '0;
        end
        for (int i = 0; i < NUM_TERMS; i++) begin
            tree[LEAVES + i] = cost_t'(sq_q[i]);
        end
        // Padding leaves are zero and fold away
        for (int n = LEAVES - 1; n >= 1; n--) begin
            tree[n] = tree[2*n] + tree[2*n + 1];
        end
    end

    // ----------------------------------------
    // Stage 2: registered sum
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && s1_valid) begin
            out_energy <= tree[1];
            out_mode   <= s1_mode;
        end
    end

endmodule

// File: source/block_cost_accum.sv
// Assumes exactly LUMA_BLOCK_SIZE rows per block and a mode held constant across them
`include "luma_cost_cfg.svh"

module block_cost_accum
    import luma_cost_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    output logic  in_ready,
    input  cost_t in_energy,
    input  mode_t in_mode,
    output logic  out_valid,
    input  logic  out_ready,
    output cost_t out_cost,
    output mode_t out_mode
);

    localparam int ROWS      = `LUMA_BLOCK_SIZE;
    localparam int ROW_CNT_W = $clog2(ROWS);

    logic [ROW_CNT_W-1:0] row_cnt;
    cost_t                sum_q;
    mode_t                block_mode;
    logic                 take;
    logic                 last_row;

    // Only a finished block waiting downstream blocks new rows
    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;
    assign last_row = (row_cnt == ROW_CNT_W'(ROWS - 1));

    // ----------------------------------------
    // Row counter and running sum
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt   <= '0;
            sum_q     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (take) begin
                if (last_row) begin
                    row_cnt   <= '0;
                    sum_q     <= '0;
                    out_valid <= 1'b1;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                    sum_q   <= sum_q + in_energy;
                end
            end
        end
    end

    // Mode latched on row 0, result on the last row
    always_ff @(posedge clk) begin
        if (take && row_cnt == '0) begin
            block_mode <= in_mode;
        end
        if (take && last_row) begin
            out_cost <= sum_q + in_energy;
            out_mode <= block_mode;
        end
    end

    // Every later row of a block carries the mode seen on its first row
    mode_steady_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        (take && row_cnt != '0) |-> (in_mode == block_mode)
    ) else $error("block_cost_accum: mode changed inside a block");

endmodule

// File: source/best_mode_select.sv
// Fixed LUMA_NUM_CANDIDATES blocks per macroblock; ties keep the earliest candidate
`include "luma_cost_cfg.svh"

module best_mode_select
    import luma_cost_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    output logic  in_ready,
    input  cost_t in_cost,
    input  mode_t in_mode,
    output logic  out_valid,
    input  logic  out_ready,
    output cost_t out_cost,
    output mode_t out_mode
);

    localparam int CANDS      = `LUMA_NUM_CANDIDATES;
    localparam int CAND_CNT_W = (CANDS > 1) ? $clog2(CANDS) : 1;

    logic [CAND_CNT_W-1:0] cand_cnt;
    cost_t                 best_cost;
    mode_t                 best_mode;
    cost_t                 win_cost;
    mode_t                 win_mode;
    logic                  take;
    logic                  last_cand;

    assign in_ready  = !out_valid || out_ready;
    assign take      = in_valid && in_ready;
    assign last_cand = (cand_cnt == CAND_CNT_W'(CANDS - 1));

    // ----------------------------------------
    // Winner so far including this candidate
    // ----------------------------------------
    always_comb begin
        win_cost = best_cost;
        win_mode = best_mode;
        // Strictly lower replaces, so equal costs leave the earlier one
        if (cand_cnt == '0 || in_cost < best_cost) begin
            win_cost = in_cost;
            win_mode = in_mode;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cand_cnt  <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (take) begin
                cand_cnt <= last_cand ? '0 : cand_cnt + 1'b1;
                if (last_cand) begin
                    out_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            best_cost <= win_cost;
            best_mode <= win_mode;
            if (last_cand) begin
                out_cost <= win_cost;
                out_mode <= win_mode;
            end
        end
    end

endmodule

// File: source/luma_cost_top.sv
// Six cycles from a macroblock's last row to its result; in_mode must hold across a block's rows
module luma_cost_top
    import luma_cost_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  coef_row_t in_ac,
    input  coef_t     in_dc,
    input  mode_t     in_mode,
    output logic      out_valid,
    input  logic      out_ready,
    output mode_t     out_mode,
    output cost_t     out_cost
);

    // ----------------------------------------
    // Inter-stage wires
    // ----------------------------------------
    row_beat_t  in_beat;
    row_beat_t  beat_q;
    logic       beat_valid;
    logic       beat_ready;

    logic       energy_valid;
    logic       energy_ready;
    cost_t      energy;
    mode_t      energy_mode;

    logic       block_valid;
    logic       block_ready;
    cost_t      block_cost;
    mode_t      block_mode;

    logic       best_valid;
    logic       best_ready;
    mode_cost_t best;
    mode_cost_t result;

    assign in_beat = '{ac: in_ac, dc: in_dc, mode: in_mode};

    pipe_stage #(.payload_t(row_beat_t)) u_in_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_beat),
        .out_valid (beat_valid),
        .out_ready (beat_ready),
        .out_data  (beat_q)
    );

    row_energy u_row_energy (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (beat_valid),
        .in_ready   (beat_ready),
        .in_ac      (beat_q.ac),
        .in_dc      (beat_q.dc),
        .in_mode    (beat_q.mode),
        .out_valid  (energy_valid),
        .out_ready  (energy_ready),
        .out_energy (energy),
        .out_mode   (energy_mode)
    );

    block_cost_accum u_block_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (energy_valid),
        .in_ready  (energy_ready),
        .in_energy (energy),
        .in_mode   (energy_mode),
        .out_valid (block_valid),
        .out_ready (block_ready),
        .out_cost  (block_cost),
        .out_mode  (block_mode)
    );

    best_mode_select u_best_select (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (block_valid),
        .in_ready  (block_ready),
        .in_cost   (block_cost),
        .in_mode   (block_mode),
        .out_valid (best_valid),
        .out_ready (best_ready),
        .out_cost  (best.cost),
        .out_mode  (best.mode)
    );

    // Output slice, result unpacked onto the ports
    pipe_stage #(.payload_t(mode_cost_t)) u_out_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (best_valid),
        .in_ready  (best_ready),
        .in_data   (best),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (result)
    );

    assign out_mode = result.mode;
    assign out_cost = result.cost;

endmodule

// File: dv/tb_luma_cost.sv
// Sends whole macroblocks only; the 6-cycle latency check is armed in the streaming test alone
`include "luma_cost_cfg.svh"

module tb_luma_cost
    import luma_cost_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BLK          = `LUMA_BLOCK_SIZE;
    localparam int CANDS        = `LUMA_NUM_CANDIDATES;
    localparam int BEATS_PER_MB = BLK * CANDS;
    // 8 sparse, 5 selection, 3 random, 3 streaming, 4 back-pressure
    localparam int NUM_MB         = 23;
    localparam int TIMEOUT_CYCLES = NUM_MB * BEATS_PER_MB * 20 + 200;
    localparam int LATENCY        = 6;
    localparam logic [15:0] SEED  = 16'd51694;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    coef_row_t in_ac;
    coef_t     in_dc;
    mode_t     in_mode;
    logic      out_valid;
    logic      out_ready;
    mode_t     out_mode;
    cost_t     out_cost;

    // Macroblock being built before it is sent
    coef_t mb_ac [CANDS][BLK][BLK];
    coef_t mb_dc [CANDS][BLK];
    mode_t mb_mode [CANDS];

    mode_t       exp_mode_q [$];
    longint      exp_cost_q [$];
    int          last_row_q [$];
    logic [15:0] data_lfsr;
    logic [15:0] bp_lfsr;
    int          err_cnt;
    int          checks;
    int          cycle_cnt;
    int          rows_seen;
    longint      max_out_cost;
    logic        lat_check;
    logic        stream_check;
    logic        bp_on;

    luma_cost_top luma_cost_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_ac     (in_ac),
        .in_dc     (in_dc),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_mode  (out_mode),
        .out_cost  (out_cost)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            val   = {val[30:0], state[0]};
        end
    endtask

    task automatic flag_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        $display("ERROR t=%0t %s: got %0d expected %0d", $time, name, got, exp);
        err_cnt++;
    endtask

    // Reference cost as the exact sum of squares over all rows
    function automatic longint block_energy(input int c);
        longint sum;
        sum = 0;
        for (int r = 0; r < BLK; r++) begin
            for (int k = 0; k < BLK; k++) begin
                sum += longint'(mb_ac[c][r][k]) * longint'(mb_ac[c][r][k]);
            end
            sum += longint'(mb_dc[c][r]) * longint'(mb_dc[c][r]);
        end
        return sum;
    endfunction

    task automatic clear_mb();
        for (int c = 0; c < CANDS; c++) begin
            mb_mode[c] = mode_t'(c);
            for (int r = 0; r < BLK; r++) begin
                mb_dc[c][r] = '0;
                for (int k = 0; k < BLK; k++) begin
                    mb_ac[c][r][k] = '0;
                end
            end
        end
    endtask

    task automatic random_mb();
        logic [31:0] v;
        for (int c = 0; c < CANDS; c++) begin
            draw_bits(data_lfsr, 4, v);
            mb_mode[c] = mode_t'(v[3:0]);
            for (int r = 0; r < BLK; r++) begin
                draw_bits(data_lfsr, 16, v);
                mb_dc[c][r] = coef_t'(v[15:0]);
                for (int k = 0; k < BLK; k++) begin
                    draw_bits(data_lfsr, 16, v);
                    mb_ac[c][r][k] = coef_t'(v[15:0]);
                end
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    // Holds the row until the posedge that accepts it
    task automatic send_row(input int c, input int r);
        @(negedge clk);
        in_valid = 1'b1;
        for (int k = 0; k < BLK; k++) begin
            in_ac[k] = mb_ac[c][r][k];
        end
        in_dc   = mb_dc[c][r];
        in_mode = mb_mode[c];
        do @(posedge clk); while (!in_ready);
    endtask

    task automatic send_mb(input logic gaps);
        longint      cost;
        longint      best_cost;
        int          best_idx;
        logic [31:0] v;
        best_cost = 0;
        best_idx  = 0;
        // Strict minimum so a tie keeps the earlier candidate
        for (int c = 0; c < CANDS; c++) begin
            cost = block_energy(c);
            if (c == 0 || cost < best_cost) begin
                best_cost = cost;
                best_idx  = c;
            end
        end
        exp_mode_q.push_back(mb_mode[best_idx]);
        exp_cost_q.push_back(best_cost);
        for (int c = 0; c < CANDS; c++) begin
            for (int r = 0; r < BLK; r++) begin
                if (gaps) begin
                    draw_bits(data_lfsr, 2, v);
                    if (v[1:0] == 2'd0) begin
                        draw_bits(data_lfsr, 2, v);
                        idle_cycles(int'(v[1:0]) + 1);
                    end
                end
                send_row(c, r);
            end
        end
    endtask

    task automatic wait_drain();
        while (exp_mode_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic check_reset_state();
        if (out_valid !== 1'b0) begin
            flag_mismatch("out_valid", out_valid, 0);
        end
        if (in_ready !== 1'b1) begin
            flag_mismatch("in_ready", in_ready, 1);
        end
    endtask

    task automatic send_sparse_blocks();
        coef_t vals [8];
        vals = '{16'sh8000, 16'sh7fff, -16'sd1, 16'sd1, -16'sd300, 16'sd12345,
                 -16'sd20000, 16'sd7};
        for (int i = 0; i < 8; i++) begin
            clear_mb();
            for (int c = 0; c < CANDS; c++) begin
                mb_mode[c] = mode_t'(i + 3 * c);
                if (i % 2 == 0) begin
                    mb_dc[c][i] = vals[i];
                end else begin
                    mb_ac[c][i][BLK-1-i] = vals[i];
                end
                // Losing candidates carry one extra full-scale value
                if (c != i % CANDS) begin
                    mb_ac[c][(i + 5) % BLK][(i + 3) % BLK] = 16'sh8000;
                end
            end
            send_mb(1'b0);
        end
        idle_cycles(1);
        wait_drain();
    endtask

    task automatic pick_lowest_modes();
        int sel [5][4];
        sel = '{'{300, 120, 500, 250}, '{400, 300, 200, 100}, '{100, 200, 300, 400},
                '{300, 150, 150, 150}, '{77, 77, 77, 77}};
        for (int i = 0; i < 5; i++) begin
            clear_mb();
            for (int c = 0; c < CANDS; c++) begin
                mb_mode[c] = mode_t'(9 + 5 * c);
                if (c % 2 == 0) begin
                    mb_dc[c][c] = coef_t'(sel[i][c]);
                end else begin
                    mb_ac[c][c][BLK-1-c] = coef_t'(-sel[i][c]);
                end
            end
            send_mb(1'b0);
        end
        idle_cycles(1);
        wait_drain();
    endtask

    task automatic send_full_range();
        max_out_cost = 0;
        repeat (3) begin
            random_mb();
            send_mb(1'b0);
        end
        idle_cycles(1);
        wait_drain();
        if (max_out_cost < 64'h1_0000_0000) begin
            $display("Reported costs never went past 32 bits at %0t", $time);
            err_cnt++;
        end
    endtask

    task automatic stream_back_to_back();
        stream_check = 1'b1;
        lat_check    = 1'b1;
        repeat (3) begin
            random_mb();
            send_mb(1'b0);
        end
        idle_cycles(1);
        wait_drain();
        stream_check = 1'b0;
        lat_check    = 1'b0;
    endtask

    task automatic apply_backpressure();
        bp_on = 1'b1;
        repeat (4) begin
            random_mb();
            send_mb(1'b1);
        end
        idle_cycles(1);
        wait_drain();
        bp_on = 1'b0;
        @(negedge clk);
        out_ready = 1'b1;
        repeat (20) @(posedge clk);
    endtask

    // ----------------------------------------
    // Stimulus, monitor, watchdog
    // ----------------------------------------
    // Output mostly stalled so finished results back up through every stage
    always @(negedge clk) begin : bp_drive
        logic [31:0] v;
        if (bp_on) begin
            draw_bits(bp_lfsr, 7, v);
            out_ready = (v[6:0] == 7'd0);
        end
    end

    always @(posedge clk) begin : monitor
        mode_t  exp_m;
        longint exp_c;
        int     last_cyc;
        if (rst_n) begin
            cycle_cnt++;
            if (stream_check && in_valid && !in_ready) begin
                $display("in_ready fell during streaming at %0t", $time);
                err_cnt++;
            end
            if (in_valid && in_ready) begin
                rows_seen++;
                if (rows_seen % BEATS_PER_MB == 0) begin
                    last_row_q.push_back(cycle_cnt);
                end
            end
            if (out_valid && out_ready) begin
                if (exp_mode_q.size() == 0) begin
                    $display("Result accepted at %0t with none pending", $time);
                    err_cnt++;
                end else begin
                    exp_m = exp_mode_q.pop_front();
                    exp_c = exp_cost_q.pop_front();
                    checks++;
                    if (longint'(out_cost) > max_out_cost) begin
                        max_out_cost = longint'(out_cost);
                    end
                    if (out_mode !== exp_m) begin
                        flag_mismatch("out_mode", out_mode, exp_m);
                    end
                    if (out_cost !== cost_t'(exp_c)) begin
                        flag_mismatch("out_cost", out_cost, exp_c);
                    end
                    if (last_row_q.size() != 0) begin
                        last_cyc = last_row_q.pop_front();
                        if (lat_check && cycle_cnt - last_cyc != LATENCY) begin
                            flag_mismatch("out_valid latency", cycle_cnt - last_cyc, LATENCY);
                        end
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d results pending",
                 TIMEOUT_CYCLES, exp_mode_q.size());
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_ac        = '0;
        in_dc        = '0;
        in_mode      = '0;
        out_ready    = 1'b1;
        data_lfsr    = SEED;
        bp_lfsr      = SEED;
        err_cnt      = 0;
        checks       = 0;
        cycle_cnt    = 0;
        rows_seen    = 0;
        max_out_cost = 0;
        lat_check    = 1'b0;
        stream_check = 1'b0;
        bp_on        = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        send_sparse_blocks();
        pick_lowest_modes();
        send_full_range();
        stream_back_to_back();
        apply_backpressure();
        if (checks != NUM_MB || last_row_q.size() != 0) begin
            $display("Got %0d results for %0d macroblocks", checks, NUM_MB);
            err_cnt++;
        end
        $display("Summary: %0d results checked, %0d errors", checks, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+source
source/luma_cost_pkg.sv
source/pipe_stage.sv
source/row_energy.sv
source/block_cost_accum.sv
source/best_mode_select.sv
source/luma_cost_top.sv
dv/tb_luma_cost.sv

// File: Bender.yml
package:
  name: luma_cost

sources:
  - include_dirs:
      - source
    files:
      - source/luma_cost_pkg.sv
      - source/pipe_stage.sv
      - source/row_energy.sv
      - source/block_cost_accum.sv
      - source/best_mode_select.sv
      - source/luma_cost_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_luma_cost.sv
